/* compile.f */
rvv_arch_pkg.sv
rvv_pipe_pkg.sv
rvv_fifo.sv
rvv_decode.sv
rvv_dispatch.sv
rvv_vrf.sv
rvv_alu.sv
rvv_retire.sv
rvv_backend.sv
rvv_backend_asserts.sv
tb_rvv_backend.sv

/* tb_rvv_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_backend;

    import rvv_arch_pkg::*;
    import rvv_pipe_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] LFSR_SEED  = 32'hfea6_fe9c;
    localparam int          N_LOAD     = NUM_VREG;
    localparam int          N_RAND     = 60;
    localparam int          N_ILLEGAL  = 6;
    localparam int          N_STALL    = 20;
    localparam int          N_STREAM   = 200;
    localparam int          N_CMDS     = N_LOAD + N_RAND + N_ILLEGAL + N_STALL + N_STREAM;
    // Both queues plus dispatch, ALU and retire
    localparam int          N_HELD     = CQ_DEPTH + UQ_DEPTH + 3;

    logic                    clk;
    logic                    rst_n;
    logic                    insts_valid;
    logic [INST_W-1:0]       insts;
    logic [XLEN-1:0]         insts_scalar;
    logic                    insts_ready;
    logic [CQ_CNT_W-1:0]     remaining_count;
    logic                    rt_valid;
    vidx_t                   rt_vd;
    vreg_t                   rt_data;
    logic                    rt_illegal;
    logic                    rt_ready;
    logic                    rvv_idle;

    // 0 always ready, 1 held low, 2 random
    logic [1:0]              rt_mode;
    logic [31:0]             stim_lfsr;
    logic [31:0]             ready_lfsr;
    vreg_t                   ref_regs [NUM_VREG];
    rt_res_t                 exp_q [$];
    int                      data_errs;
    int                      idx_errs;
    int                      flag_errs;
    int                      count_errs;
    int                      other_errs;

    rvv_backend u_rvv_backend (
        .clk(clk), .rst_n(rst_n),
        .insts_valid(insts_valid), .insts(insts), .insts_scalar(insts_scalar),
        .insts_ready(insts_ready), .remaining_count(remaining_count),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data),
        .rt_illegal(rt_illegal), .rt_ready(rt_ready), .rvv_idle(rvv_idle)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic vreg_t splat(logic [XLEN-1:0] s);
        return {NUM_ELEM{s[SEW-1:0]}};
    endfunction

    // Expected lane results with 8-bit wrap
    function automatic vreg_t ref_alu(alu_op_e op, vreg_t a, vreg_t b);
        vreg_t          r;
        logic [SEW-1:0] x;
        logic [SEW-1:0] y;
        r = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            x = a[i*SEW +: SEW];
            y = b[i*SEW +: SEW];
            case (op)
                ALU_ADD: r[i*SEW +: SEW] = x + y;
                ALU_SUB: r[i*SEW +: SEW] = x - y;
                ALU_AND: r[i*SEW +: SEW] = x & y;
                ALU_OR:  r[i*SEW +: SEW] = x | y;
                ALU_XOR: r[i*SEW +: SEW] = x ^ y;
                default: r[i*SEW +: SEW] = y;
            endcase
        end
        return r;
    endfunction

    task automatic check_vreg(input vreg_t got, input vreg_t exp, input string what);
        if (got !== exp) begin
            data_errs++;
            $display("CHECK FAILED time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(input vidx_t got, input vidx_t exp, input string what);
        if (got !== exp) begin
            idx_errs++;
            $display("CHECK FAILED time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("CHECK FAILED time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [CQ_CNT_W-1:0] got, input logic [CQ_CNT_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            count_errs++;
            $display("CHECK FAILED time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Errors: data %0d, index %0d, flag %0d, count %0d, other %0d",
                 data_errs, idx_errs, flag_errs, count_errs, other_errs);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // Starts 10 ns after an edge and returns 10 ns after the accepting edge
    task automatic send_cmd(input logic [INST_W-1:0] inst, input logic [XLEN-1:0] scalar);
        insts_valid  = 1'b1;
        insts        = inst;
        insts_scalar = scalar;
        while (!insts_ready) begin
            @(posedge clk);
            #10;
        end
        @(posedge clk);
        #10;
        insts_valid = 1'b0;
    endtask

    task automatic issue_op(input alu_op_e op, input logic vx, input vidx_t vd,
                            input vidx_t vs2, input vidx_t vs1, input logic [XLEN-1:0] scalar);
        logic [5:0] f6;
        vreg_t      b;
        rt_res_t    e;
        case (op)
            ALU_ADD: f6 = F6_VADD;
            ALU_SUB: f6 = F6_VSUB;
            ALU_AND: f6 = F6_VAND;
            ALU_OR:  f6 = F6_VOR;
            ALU_XOR: f6 = F6_VXOR;
            default: f6 = F6_VMV;
        endcase
        b         = vx ? splat(scalar) : ref_regs[vs1];
        e.vd      = vd;
        e.data    = ref_alu(op, ref_regs[vs2], b);
        e.illegal = 1'b0;
        ref_regs[vd] = e.data;
        exp_q.push_back(e);
        send_cmd({f6, 1'b1, vs2, vs1, vx ? F3_OPIVX : F3_OPIVV, vd, OPCODE_V}, scalar);
    endtask

    task automatic issue_illegal(input logic [INST_W-1:0] inst);
        rt_res_t e;
        e.vd      = inst[11:7];
        e.data    = '0;
        e.illegal = 1'b1;
        exp_q.push_back(e);
        send_cmd(inst, 32'h5a5a_5a5a);
    endtask

    task automatic random_op(input int idx_bits);
        logic [31:0] r;
        logic [31:0] scalar;
        vidx_t       vd;
        vidx_t       vs2;
        vidx_t       vs1;
        alu_op_e     op;
        logic        vx;
        take_bits(stim_lfsr, 3, r);
        vx = 1'b0;
        case (r[2:0])
            3'd0: op = ALU_ADD;
            3'd1: op = ALU_SUB;
            3'd2: op = ALU_AND;
            3'd3: op = ALU_OR;
            3'd4: op = ALU_XOR;
            3'd5: begin
                op = ALU_ADD;
                vx = 1'b1;
            end
            default: begin
                op = ALU_MV;
                vx = 1'b1;
            end
        endcase
        take_bits(stim_lfsr, idx_bits, r);
        vd = vidx_t'(r);
        take_bits(stim_lfsr, idx_bits, r);
        vs2 = (op == ALU_MV) ? '0 : vidx_t'(r);
        take_bits(stim_lfsr, idx_bits, r);
        vs1 = vidx_t'(r);
        take_bits(stim_lfsr, 32, scalar);
        issue_op(op, vx, vd, vs2, vs1, scalar);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_flag(rvv_idle, 1'b1, "rvv_idle after drain");
        @(posedge clk);
        #10;
    endtask

    // Mode sampled on the edge and ready driven 10 ns later
    always @(posedge clk) begin
        logic [1:0]  mode;
        logic [31:0] r;
        mode = rt_mode;
        #10;
        case (mode)
            2'd0: rt_ready = 1'b1;
            2'd1: rt_ready = 1'b0;
            default: begin
                take_bits(ready_lfsr, 1, r);
                rt_ready = r[0];
            end
        endcase
    end

    // Retirements compared mid-cycle before the handshake edge
    always @(negedge clk) begin
        rt_res_t e;
        if (rst_n && rt_valid && rt_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Retirement of v%0d at time %0t with no command outstanding",
                         rt_vd, $time);
            end else begin
                e = exp_q.pop_front();
                check_idx(rt_vd, e.vd, "rt_vd");
                check_vreg(rt_data, e.data, "rt_data");
                check_flag(rt_illegal, e.illegal, "rt_illegal");
            end
        end
    end

    initial begin
        #(CLK_PERIOD * 40 * N_CMDS);
        $display("Watchdog expired after %0d cycles with %0d retirements outstanding",
                 40 * N_CMDS, exp_q.size());
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [CQ_CNT_W-1:0] accepted;
        logic [31:0]         r;
        clk          = 1'b0;
        rst_n        = 1'b0;
        insts_valid  = 1'b0;
        insts        = '0;
        insts_scalar = '0;
        rt_ready     = 1'b0;
        rt_mode      = 2'd0;
        stim_lfsr    = LFSR_SEED;
        ready_lfsr   = LFSR_SEED;
        data_errs    = 0;
        idx_errs     = 0;
        flag_errs    = 0;
        count_errs   = 0;
        other_errs   = 0;
        for (int i = 0; i < NUM_VREG; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_flag(insts_ready, 1'b1, "insts_ready after reset");
        check_flag(rt_valid, 1'b0, "rt_valid after reset");
        check_flag(rvv_idle, 1'b1, "rvv_idle after reset");
        check_count(remaining_count, CQ_CNT_W'(CQ_DEPTH), "remaining_count after reset");

        // Splat loads into every register
        for (int i = 0; i < N_LOAD; i++) begin
            take_bits(stim_lfsr, 32, r);
            issue_op(ALU_MV, 1'b1, vidx_t'(i), '0, '0, r);
        end
        wait_drain();

        // Dense dependencies over eight registers
        for (int i = 0; i < N_RAND; i++) begin
            random_op(3);
        end
        wait_drain();

        // Unsupported funct6, a masked form and the OPMVV category
        issue_illegal({6'b100101, 1'b1, 5'd1, 5'd2, F3_OPIVV, 5'd5, OPCODE_V});
        issue_illegal({F6_VADD, 1'b0, 5'd1, 5'd2, F3_OPIVV, 5'd6, OPCODE_V});
        issue_illegal({F6_VADD, 1'b1, 5'd1, 5'd2, 3'b010, 5'd7, OPCODE_V});
        for (int i = 5; i < 8; i++) begin
            issue_op(ALU_OR, 1'b0, vidx_t'(i + 19), vidx_t'(i), vidx_t'(i), '0);
        end
        wait_drain();

        // Retire blocked until every stage is full
        rt_mode = 2'd1;
        idle(2);
        accepted = '0;
        for (int i = 0; i < N_STALL; i++) begin
            check_flag(insts_ready, accepted != CQ_CNT_W'(N_HELD), "insts_ready while filling");
            if (!insts_ready) begin
                break;
            end
            issue_op(ALU_ADD, 1'b0, vidx_t'(8 + i), vidx_t'(i % 8), vidx_t'((i + 1) % 8), '0);
            accepted = accepted + 1'b1;
        end
        check_count(accepted, CQ_CNT_W'(N_HELD), "commands held");
        check_count(remaining_count, '0, "remaining_count when full");
        idle(10);
        check_flag(insts_ready, 1'b0, "insts_ready while blocked");
        check_flag(rvv_idle, 1'b0, "rvv_idle while blocked");
        rt_mode = 2'd0;
        wait_drain();

        // Long stream under random back-pressure
        rt_mode = 2'd2;
        for (int i = 0; i < N_STREAM; i++) begin
            take_bits(stim_lfsr, 2, r);
            if (r[1:0] == 2'b00) begin
                idle(1);
            end
            random_op(5);
        end
        wait_drain();

        print_counts();
        if (data_errs + idx_errs + flag_errs + count_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rvv_backend_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_asserts (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              insts_ready,
    input logic [rvv_pipe_pkg::CQ_CNT_W-1:0] remaining_count,
    input logic                              rt_valid,
    input rvv_arch_pkg::vidx_t               rt_vd,
    input rvv_arch_pkg::vreg_t               rt_data,
    input logic                              rt_illegal,
    input logic                              rt_ready,
    input logic                              req_valid,
    input logic                              res_valid
);

    full_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        (remaining_count == '0) |-> !insts_ready)
        else $error("insts_ready high with no free command queue entry");

    // Stalled retirement keeps its payload
    rt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rt_valid && !rt_ready) |=> (rt_valid && $stable(rt_vd) && $stable(rt_data)
                                     && $stable(rt_illegal)))
        else $error("rt_valid dropped or retired payload changed before rt_ready");

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!rt_valid && !req_valid && !res_valid && insts_ready))
        else $error("valid signal high or insts_ready low in the cycle after reset");

endmodule

bind rvv_backend rvv_backend_asserts u_asserts (
    .clk(clk), .rst_n(rst_n),
    .insts_ready(insts_ready), .remaining_count(remaining_count),
    .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data),
    .rt_illegal(rt_illegal), .rt_ready(rt_ready),
    .req_valid(req_valid_dp2alu), .res_valid(res_valid_alu2rt)
);

`default_nettype wire

/* rvv_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_backend (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 insts_valid,
    input  logic [rvv_arch_pkg::INST_W-1:0]      insts,
    input  logic [rvv_arch_pkg::XLEN-1:0]        insts_scalar,
    output logic                                 insts_ready,
    output logic [rvv_pipe_pkg::CQ_CNT_W-1:0]    remaining_count,
    output logic                                 rt_valid,
    output rvv_arch_pkg::vidx_t                  rt_vd,
    output rvv_arch_pkg::vreg_t                  rt_data,
    output logic                                 rt_illegal,
    input  logic                                 rt_ready,
    output logic                                 rvv_idle
);

    import rvv_arch_pkg::*;
    import rvv_pipe_pkg::*;

    rvv_cmd_t              cmd_in;
    rvv_cmd_t              cmd_cq2de;
    logic                  cq_full;
    logic                  cq_empty;
    logic [CQ_CNT_W-1:0]   cq_count;
    logic                  pop_de2cq;
    rvv_uop_t              uop_de2uq;
    logic                  push_de2uq;
    logic                  uq_full;
    logic                  uq_empty;
    rvv_uop_t              uop_uq2dp;
    logic                  uop_ready_dp2uq;
    vidx_t                 rd_idx_a;
    vidx_t                 rd_idx_b;
    vreg_t                 rd_data_a;
    vreg_t                 rd_data_b;
    alu_req_t              req_dp2alu;
    logic                  req_valid_dp2alu;
    logic                  req_ready_alu2dp;
    rt_res_t               res_alu2rt;
    logic                  res_valid_alu2rt;
    logic                  res_ready_rt2alu;
    logic                  wr_en;
    vidx_t                 wr_idx;
    vreg_t                 wr_data;
    logic                  clr_valid;
    vidx_t                 clr_idx;
    logic                  busy_any;

    assign cmd_in          = '{inst: insts, scalar: insts_scalar};
    assign insts_ready     = ~cq_full;
    assign remaining_count = CQ_CNT_W'(CQ_DEPTH) - cq_count;

    rvv_fifo #(.T(rvv_cmd_t), .DEPTH(CQ_DEPTH)) u_cmd_queue (
        .clk(clk), .rst_n(rst_n),
        .push(insts_valid & insts_ready), .din(cmd_in),
        .pop(pop_de2cq), .dout(cmd_cq2de),
        .full(cq_full), .empty(cq_empty), .count(cq_count)
    );

    rvv_decode u_decode (
        .cmd(cmd_cq2de), .cmd_valid(~cq_empty), .cmd_pop(pop_de2cq),
        .uop(uop_de2uq), .uop_push(push_de2uq), .uq_full(uq_full)
    );

    rvv_fifo #(.T(rvv_uop_t), .DEPTH(UQ_DEPTH)) u_uop_queue (
        .clk(clk), .rst_n(rst_n),
        .push(push_de2uq), .din(uop_de2uq),
        .pop(~uq_empty & uop_ready_dp2uq), .dout(uop_uq2dp),
        .full(uq_full), .empty(uq_empty), .count()
    );

    rvv_dispatch u_dispatch (
        .clk(clk), .rst_n(rst_n),
        .uop(uop_uq2dp), .uop_valid(~uq_empty), .uop_ready(uop_ready_dp2uq),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .req(req_dp2alu), .req_valid(req_valid_dp2alu), .req_ready(req_ready_alu2dp),
        .clr_valid(clr_valid), .clr_idx(clr_idx), .busy_any(busy_any)
    );

    rvv_vrf u_vrf (
        .clk(clk), .rst_n(rst_n),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    rvv_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .req(req_dp2alu), .req_valid(req_valid_dp2alu), .req_ready(req_ready_alu2dp),
        .res(res_alu2rt), .res_valid(res_valid_alu2rt), .res_ready(res_ready_rt2alu)
    );

    rvv_retire u_retire (
        .clk(clk), .rst_n(rst_n),
        .res(res_alu2rt), .res_valid(res_valid_alu2rt), .res_ready(res_ready_rt2alu),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data),
        .rt_illegal(rt_illegal), .rt_ready(rt_ready),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .clr_valid(clr_valid), .clr_idx(clr_idx)
    );

    // Idle once nothing is queued, in flight or pending a write
    assign rvv_idle = cq_empty & uq_empty & ~req_valid_dp2alu & ~res_valid_alu2rt
                    & ~rt_valid & ~busy_any;

endmodule

`default_nettype wire

/* rvv_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_retire (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rvv_pipe_pkg::rt_res_t res,
    input  logic                  res_valid,
    output logic                  res_ready,
    output logic                  rt_valid,
    output rvv_arch_pkg::vidx_t   rt_vd,
    output rvv_arch_pkg::vreg_t   rt_data,
    output logic                  rt_illegal,
    input  logic                  rt_ready,
    output logic                  wr_en,
    output rvv_arch_pkg::vidx_t   wr_idx,
    output rvv_arch_pkg::vreg_t   wr_data,
    output logic                  clr_valid,
    output rvv_arch_pkg::vidx_t   clr_idx
);

    logic commit;

    assign res_ready = ~rt_valid | rt_ready;

    // Register write and busy clear both happen on the retire handshake
    assign commit    = rt_valid & rt_ready & ~rt_illegal;
    assign wr_en     = commit;
    assign wr_idx    = rt_vd;
    assign wr_data   = rt_data;
    assign clr_valid = commit;
    assign clr_idx   = rt_vd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt_valid <= 1'b0;
        end else if (res_ready) begin
            rt_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            rt_vd      <= res.vd;
            rt_data    <= res.data;
            rt_illegal <= res.illegal;
        end
    end

endmodule

`default_nettype wire

/* rvv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rvv_pipe_pkg::alu_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output rvv_pipe_pkg::rt_res_t  res,
    output logic                   res_valid,
    input  logic                   res_ready
);

    import rvv_arch_pkg::*;

    logic [SEW-1:0] a_e;
    logic [SEW-1:0] b_e;
    vreg_t          result;

    assign req_ready = ~res_valid | res_ready;

    // Lanes are independent, no carries between elements
    always_comb begin
        result = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            a_e = req.src_a[i*SEW +: SEW];
            b_e = req.src_b[i*SEW +: SEW];
            case (req.op)
                ALU_ADD: result[i*SEW +: SEW] = a_e + b_e;
                ALU_SUB: result[i*SEW +: SEW] = a_e - b_e;
                ALU_AND: result[i*SEW +: SEW] = a_e & b_e;
                ALU_OR:  result[i*SEW +: SEW] = a_e | b_e;
                ALU_XOR: result[i*SEW +: SEW] = a_e ^ b_e;
                default: result[i*SEW +: SEW] = b_e;
            endcase
        end
        if (req.illegal) begin
            result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (req_ready) begin
            res_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            res.vd      <= req.vd;
            res.data    <= result;
            res.illegal <= req.illegal;
        end
    end

endmodule

`default_nettype wire

/* rvv_vrf.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_vrf (
    input  logic                clk,
    input  logic                rst_n,
    input  rvv_arch_pkg::vidx_t rd_idx_a,
    input  rvv_arch_pkg::vidx_t rd_idx_b,
    output rvv_arch_pkg::vreg_t rd_data_a,
    output rvv_arch_pkg::vreg_t rd_data_b,
    input  logic                wr_en,
    input  rvv_arch_pkg::vidx_t wr_idx,
    input  rvv_arch_pkg::vreg_t wr_data
);

    import rvv_arch_pkg::*;

    vreg_t regs [NUM_VREG];

    // No write bypass, dispatch waits until the write has landed
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* rvv_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rvv_pipe_pkg::rvv_uop_t uop,
    input  logic                   uop_valid,
    output logic                   uop_ready,
    output rvv_arch_pkg::vidx_t    rd_idx_a,
    output rvv_arch_pkg::vidx_t    rd_idx_b,
    input  rvv_arch_pkg::vreg_t    rd_data_a,
    input  rvv_arch_pkg::vreg_t    rd_data_b,
    output rvv_pipe_pkg::alu_req_t req,
    output logic                   req_valid,
    input  logic                   req_ready,
    input  logic                   clr_valid,
    input  rvv_arch_pkg::vidx_t    clr_idx,
    output logic                   busy_any
);

    import rvv_arch_pkg::*;

    logic [NUM_VREG-1:0] busy;
    logic [NUM_VREG-1:0] busy_nxt;
    logic                hazard;
    logic                accept;
    vreg_t               src_b;

    assign rd_idx_a = uop.vs_a;
    assign rd_idx_b = uop.vs_b;

    // A scalar form has no second register source
    // Waiting on vd as well keeps one outstanding writer per busy bit
    assign hazard = busy[uop.vs_a]
                  | (~uop.scalar_en & busy[uop.vs_b])
                  | (~uop.illegal & busy[uop.vd]);

    assign uop_ready = ~hazard & (~req_valid | req_ready);
    assign accept    = uop_valid & uop_ready;
    assign busy_any  = |busy;

    // Scalar low byte replicated into every element
    assign src_b = uop.scalar_en ? {NUM_ELEM{uop.scalar[SEW-1:0]}} : rd_data_b;

    always_comb begin
        busy_nxt = busy;
        if (clr_valid) begin
            busy_nxt[clr_idx] = 1'b0;
        end
        if (accept && !uop.illegal) begin
            busy_nxt[uop.vd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            busy      <= '0;
        end else begin
            busy <= busy_nxt;
            if (accept) begin
                req_valid <= 1'b1;
            end else if (req_ready) begin
                req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.op      <= uop.op;
            req.vd      <= uop.vd;
            req.src_a   <= rd_data_a;
            req.src_b   <= src_b;
            req.illegal <= uop.illegal;
        end
    end

endmodule

`default_nettype wire

/* rvv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_decode (
    input  rvv_pipe_pkg::rvv_cmd_t cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_pop,
    output rvv_pipe_pkg::rvv_uop_t uop,
    output logic                   uop_push,
    input  logic                   uq_full
);

    import rvv_arch_pkg::*;

    logic [5:0] funct6;
    logic       vm;
    logic [2:0] funct3;
    logic [6:0] opcode;

    assign funct6 = cmd.inst[31:26];
    assign vm     = cmd.inst[25];
    assign funct3 = cmd.inst[14:12];
    assign opcode = cmd.inst[6:0];

    // One command per cycle, straight through
    assign cmd_pop  = cmd_valid & ~uq_full;
    assign uop_push = cmd_pop;

    always_comb begin
        uop.vd        = cmd.inst[11:7];
        uop.vs_a      = cmd.inst[24:20];
        uop.vs_b      = cmd.inst[19:15];
        uop.scalar    = cmd.scalar;
        uop.op        = ALU_ADD;
        uop.scalar_en = 1'b0;
        uop.illegal   = 1'b0;
        case (funct3)
            F3_OPIVV: begin
                case (funct6)
                    F6_VADD: uop.op = ALU_ADD;
                    F6_VSUB: uop.op = ALU_SUB;
                    F6_VAND: uop.op = ALU_AND;
                    F6_VOR:  uop.op = ALU_OR;
                    F6_VXOR: uop.op = ALU_XOR;
                    default: uop.illegal = 1'b1;
                endcase
            end
            F3_OPIVX: begin
                uop.scalar_en = 1'b1;
                case (funct6)
                    F6_VADD: uop.op = ALU_ADD;
                    F6_VMV:  uop.op = ALU_MV;
                    default: uop.illegal = 1'b1;
                endcase
            end
            default: uop.illegal = 1'b1;
        endcase
        // Masked forms are not supported
        if (opcode != OPCODE_V || !vm) begin
            uop.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rvv_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  T                       din,
    input  logic                   pop,
    output T                       dout,
    output logic                   full,
    output logic                   empty,
    output logic [$clog2(DEPTH):0] count
);

    localparam int PTR_W = $clog2(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Writes into a full queue and reads from an empty one are ignored
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full  = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rvv_pipe_pkg.sv */
`default_nettype none

package rvv_pipe_pkg;

    localparam int CQ_DEPTH = 8;
    localparam int UQ_DEPTH = 4;
    localparam int CQ_CNT_W = $clog2(CQ_DEPTH) + 1;

    // Command queue entry
    typedef struct packed {
        logic [rvv_arch_pkg::INST_W-1:0] inst;
        logic [rvv_arch_pkg::XLEN-1:0]   scalar;
    } rvv_cmd_t;

    // Uop queue entry, vs_a is vs2 and vs_b is vs1/rs1
    typedef struct packed {
        rvv_arch_pkg::alu_op_e         op;
        rvv_arch_pkg::vidx_t           vd;
        rvv_arch_pkg::vidx_t           vs_a;
        rvv_arch_pkg::vidx_t           vs_b;
        logic                          scalar_en;
        logic [rvv_arch_pkg::XLEN-1:0] scalar;
        logic                          illegal;
    } rvv_uop_t;

    // Operands already read from the register file
    typedef struct packed {
        rvv_arch_pkg::alu_op_e op;
        rvv_arch_pkg::vidx_t   vd;
        rvv_arch_pkg::vreg_t   src_a;
        rvv_arch_pkg::vreg_t   src_b;
        logic                  illegal;
    } alu_req_t;

    typedef struct packed {
        rvv_arch_pkg::vidx_t vd;
        rvv_arch_pkg::vreg_t data;
        logic                illegal;
    } rt_res_t;

endpackage

`default_nettype wire

/* rvv_arch_pkg.sv */
`default_nettype none

package rvv_arch_pkg;

    // VLEN 128, SEW 8, LMUL 1
    localparam int VLEN       = 128;
    localparam int SEW        = 8;
    localparam int NUM_ELEM   = VLEN / SEW;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;
    localparam int XLEN       = 32;
    localparam int INST_W     = 32;

    typedef logic [VLEN-1:0]       vreg_t;
    typedef logic [VREG_IDX_W-1:0] vidx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_MV
    } alu_op_e;

    // OP-V major opcode and the funct3 categories in use
    localparam logic [6:0] OPCODE_V = 7'b1010111;
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVX = 3'b100;

    localparam logic [5:0] F6_VADD  = 6'b000000;
    localparam logic [5:0] F6_VSUB  = 6'b000010;
    localparam logic [5:0] F6_VAND  = 6'b001001;
    localparam logic [5:0] F6_VOR   = 6'b001010;
    localparam logic [5:0] F6_VXOR  = 6'b001011;
    localparam logic [5:0] F6_VMV   = 6'b010111;

endpackage

`default_nettype wire
